// File: tb/rob_tests.txt
# One command per line, values in hex
# test <name> | alloc <pc> <dest> <branch> | update <tag> <word>
# commit <pc> <dest> <value> | erase <tag> | random <cycles>
test fill
alloc 00400000 01 0
alloc 00400004 02 0
alloc 00400008 03 0
alloc 0040000c 00 1
alloc 00400010 05 0
alloc 00400014 06 0
alloc 00400018 07 0
alloc 0040001c 08 0
alloc 00400020 09 0
test commit_order
update 2 00000022
update 1 00000011
update 0 00000010
commit 00400000 01 00000010
commit 00400004 02 00000011
commit 00400008 03 00000022
test branch_decode
update 3 80100040
commit 0040000c 00 80100040
test erase
erase 6
alloc 00400100 0a 0
update 4 00000044
update 5 00000055
update 6 00000066
commit 00400010 05 00000044
commit 00400014 06 00000055
commit 00400100 0a 00000066
test erase_head
alloc 00400200 0b 0
erase 7
test random_run
random 28
random 28
random 28

// File: list.f
design/rob_cfg_pkg.sv
design/rob_entry_pkg.sv
design/rob_ctrl.sv
design/rob_ptr.sv
design/rob_store.sv
design/rob_top.sv
tb/rob_clk_gen.sv
tb/rob_asserts.sv
tb/rob_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module rob_tb
	./obj_dir/Vrob_tb | tee /dev/stderr | grep "Testbench passed" > /dev/null

clean:
	rm -rf obj_dir

// File: tb/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

  import rob_cfg_pkg::*;
  import rob_entry_pkg::*;

  localparam int DEPTH           = rob_depth;
  localparam int ADDR_W          = rob_addr_w;
  localparam int CYCLES_PER_LINE = 50;

  typedef struct packed {
    logic [ADDR_W-1:0] tag;
    logic [31:0]       pc;
    logic [4:0]        dest;
    logic              br;
    logic              done;
    logic [31:0]       word;
  } entry_t;

  logic              clk;
  logic              rst;
  logic              write_en;
  logic [31:0]       write_pc;
  logic [4:0]        write_dest;
  logic              write_is_branch;
  logic              can_write;
  logic [ADDR_W-1:0] rob_addr;
  logic              update_en;
  logic [ADDR_W-1:0] update_addr;
  rob_result_u       update_result;
  logic              commit_en;
  logic              can_commit;
  logic [31:0]       commit_pc;
  logic [4:0]        commit_dest;
  logic [31:0]       commit_value;
  logic              commit_is_branch;
  logic              commit_taken;
  logic [31:0]       commit_target;
  logic              erase_en;
  logic [ADDR_W-1:0] erase_from_addr;

  // Reference model with the oldest entry at the front
  entry_t            model_q[$];
  logic [ADDR_W-1:0] model_tail;
  logic [31:0]       rand_state;
  logic [127:0]      test_name;
  bit                test_open;
  int                errors;
  int                errors_at_start;
  int                tests_run;
  int                tests_failed;

  rob_clk_gen #(.PERIOD(20), .RESET_CYCLES(5)) i_clk_gen (.clk(clk), .rst(rst));

  rob_top #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) i_rob_top (
    .clk(clk), .rst(rst),
    .write_en(write_en), .write_pc(write_pc), .write_dest(write_dest),
    .write_is_branch(write_is_branch), .can_write(can_write), .rob_addr(rob_addr),
    .update_en(update_en), .update_addr(update_addr), .update_result(update_result),
    .commit_en(commit_en), .can_commit(can_commit), .commit_pc(commit_pc),
    .commit_dest(commit_dest), .commit_value(commit_value),
    .commit_is_branch(commit_is_branch), .commit_taken(commit_taken),
    .commit_target(commit_target),
    .erase_en(erase_en), .erase_from_addr(erase_from_addr)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Checking helpers
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%0t %s", $time, msg);
  endtask

  task automatic check_levels();
    check("can_write", 32'(can_write), 32'(model_q.size() < DEPTH));
    check("can_commit", 32'(can_commit), 32'(model_q.size() > 0 && model_q[0].done));
    check("rob_addr", 32'(rob_addr), 32'(model_tail));
  endtask

  task automatic close_test();
    if (test_open) begin
      tests_run++;
      if (errors == errors_at_start) begin
        $display("Test %0s: ok", test_name);
      end else begin
        tests_failed++;
        $display("Test %0s: %0d errors", test_name, errors - errors_at_start);
      end
    end
  endtask

  task automatic open_test(input logic [127:0] name);
    close_test();
    test_name       = name;
    errors_at_start = errors;
    test_open       = 1'b1;
  endtask

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state >> 8;
  endfunction

  function automatic int find_tag(input logic [ADDR_W-1:0] tag);
    foreach (model_q[i]) begin
      if (model_q[i].tag == tag) begin
        return i;
      end
    end
    return -1;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Commands
  // ~~~~~~~~~~~~~~~~~~~~

  // A full buffer leaves the write undriven, as a caller holding its request would
  task automatic alloc_entry(input logic [31:0] pc, input logic [4:0] dest, input logic br);
    entry_t e;
    check_levels();
    if (model_q.size() < DEPTH) begin
      e.tag = model_tail;
      e.pc = pc;
      e.dest = dest;
      e.br = br;
      e.done = 1'b0;
      e.word = '0;
      write_en        = 1'b1;
      write_pc        = pc;
      write_dest      = dest;
      write_is_branch = br;
      model_q.push_back(e);
      model_tail = model_tail + 1'b1;
    end
    @(negedge clk);
    write_en = 1'b0;
  endtask

  task automatic update_entry(input logic [ADDR_W-1:0] tag, input logic [31:0] word);
    int     idx;
    entry_t e;
    check_levels();
    idx = find_tag(tag);
    if (idx < 0) begin
      report_failure($sformatf("Update to tag %0d, which holds no live entry", tag));
    end else begin
      update_en          = 1'b1;
      update_addr        = tag;
      update_result.data = word;
      e = model_q[idx];
      e.done = 1'b1;
      e.word = word;
      model_q[idx] = e;
    end
    @(negedge clk);
    update_en = 1'b0;
  endtask

  task automatic commit_head(input logic [31:0] pc, input logic [4:0] dest,
                             input logic [31:0] value);
    check_levels();
    if (model_q.size() == 0 || !model_q[0].done) begin
      report_failure("Commit requested while the head entry is not complete");
    end else begin
      check("commit_pc", commit_pc, pc);
      check("commit_dest", 32'(commit_dest), 32'(dest));
      check("commit_value", commit_value, value);
      check("commit_is_branch", 32'(commit_is_branch), 32'(model_q[0].br));
      // The branch view keeps taken in the top bit and the target word address below it
      check("commit_taken", 32'(commit_taken), 32'(value[31]));
      check("commit_target", commit_target, {value[30:0], 1'b0});
      commit_en = 1'b1;
      void'(model_q.pop_front());
    end
    @(negedge clk);
    commit_en = 1'b0;
  endtask

  task automatic erase_from(input logic [ADDR_W-1:0] tag);
    int idx;
    check_levels();
    idx = find_tag(tag);
    if (idx < 0) begin
      report_failure($sformatf("Erase from tag %0d, which holds no live entry", tag));
      @(negedge clk);
    end else begin
      erase_en        = 1'b1;
      erase_from_addr = tag;
      while (model_q.size() > idx) begin
        void'(model_q.pop_back());
      end
      model_tail = tag;
      @(negedge clk);
      erase_en = 1'b0;
      check("can_write in flush", 32'(can_write), 32'd0);
      check("can_commit in flush", 32'(can_commit), 32'd0);
      @(negedge clk);
    end
  endtask

  task automatic random_mix(input int count);
    logic [31:0] r;
    logic [31:0] v;
    int          sel;
    int          idx;
    repeat (count) begin
      r   = next_rand();
      v   = next_rand();
      sel = int'(r % 32'd3);
      if (sel == 0 && model_q.size() < DEPTH) begin
        alloc_entry({8'h00, v[21:0], 2'b00}, v[26:22], v[27]);
      end else if (sel == 1 && model_q.size() > 0) begin
        idx = int'(v % 32'(model_q.size()));
        update_entry(model_q[idx].tag, next_rand());
      end else if (sel == 2 && model_q.size() > 0 && model_q[0].done) begin
        commit_head(model_q[0].pc, model_q[0].dest, model_q[0].word);
      end else begin
        check_levels();
        @(negedge clk);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Main sequence
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    int           fd;
    int           code;
    int           n;
    string        line;
    logic [63:0]  cmd;
    logic [127:0] name;
    logic [31:0]  a;
    logic [31:0]  b;
    logic [31:0]  c;
    write_en        = 1'b0;
    write_pc        = '0;
    write_dest      = '0;
    write_is_branch = 1'b0;
    update_en       = 1'b0;
    update_addr     = '0;
    update_result   = '0;
    commit_en       = 1'b0;
    erase_en        = 1'b0;
    erase_from_addr = '0;
    model_tail      = '0;
    rand_state      = 32'd8892;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    test_open       = 1'b0;

    // The sweep must hold the buffer closed for one cycle per entry
    open_test("reset_sweep");
    @(posedge rst);
    n = 0;
    while (!can_write && n <= DEPTH + 4) begin
      check("can_commit", 32'(can_commit), 32'd0);
      @(negedge clk);
      n++;
    end
    check("sweep cycles", 32'(n), 32'(DEPTH));

    fd = $fopen("tb/rob_tests.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open tb/rob_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          cmd  = '0;
          code = $sscanf(line, "%s %h %h %h", cmd, a, b, c);
          if (cmd == 64'("test")) begin
            code = $sscanf(line, "%s %s", cmd, name);
            open_test(name);
          end else if (cmd == 64'("alloc")) begin
            alloc_entry(a, b[4:0], c[0]);
          end else if (cmd == 64'("update")) begin
            update_entry(a[ADDR_W-1:0], b);
          end else if (cmd == 64'("commit")) begin
            commit_head(a, b[4:0], c);
          end else if (cmd == 64'("erase")) begin
            erase_from(a[ADDR_W-1:0]);
          end else if (cmd == 64'("random")) begin
            random_mix(int'(a));
          end else begin
            report_failure($sformatf("Unknown command in test file: %s", line));
          end
        end
      end
      $fclose(fd);
    end
    close_test();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Budget of cycles per line of the test file on top of reset and sweep
  initial begin : watchdog
    int    fd;
    int    code;
    int    lines;
    string line;
    lines = 0;
    fd = $fopen("tb/rob_tests.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0) begin
          lines++;
        end
      end
      $fclose(fd);
    end
    repeat (lines * CYCLES_PER_LINE + DEPTH + 20) @(posedge clk);
    $display("Timeout: the tests did not finish in the expected number of cycles");
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: tb/rob_asserts.sv
`timescale 1ns/1ps

module rob_asserts #(
  parameter int ADDR_W = rob_cfg_pkg::rob_addr_w
) (
  input logic              clk,
  input logic              rst,
  input logic              can_write,
  input logic              can_commit,
  input logic              full,
  input logic              empty,
  input logic [ADDR_W-1:0] head,
  input logic [ADDR_W-1:0] tail
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Level invariants
  // ~~~~~~~~~~~~~~~~~~~~

  assert property (@(posedge clk) !rst |-> !can_write && !can_commit)
    else $error("can_write or can_commit high while reset is held");

  // Equal pointers mean the buffer holds either no entries or all of them
  assert property (@(posedge clk) disable iff (!rst) can_write && head == tail |-> empty)
    else $error("can_write high while the buffer is full");

  // Nothing can retire from an empty buffer
  assert property (@(posedge clk) disable iff (!rst) can_commit && head == tail |-> full)
    else $error("can_commit high while the buffer is empty");

endmodule

bind rob_top rob_asserts #(.ADDR_W(ADDR_W)) i_rob_asserts (
  .clk        (clk),
  .rst        (rst),
  .can_write  (can_write),
  .can_commit (can_commit),
  .full       (full),
  .empty      (empty),
  .head       (head),
  .tail       (tail)
);

// File: tb/rob_clk_gen.sv
`timescale 1ns/1ps

module rob_clk_gen #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release away from the rising edge so the first sweep edge sees a clean reset
  initial begin
    rst = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
  end

endmodule

// File: design/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
  parameter int DEPTH  = rob_cfg_pkg::rob_depth,
  parameter int ADDR_W = rob_cfg_pkg::rob_addr_w
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                write_en,
  input  logic [rob_entry_pkg::addr_w-1:0]     write_pc,
  input  logic [rob_entry_pkg::reg_addr_w-1:0] write_dest,
  input  logic                                write_is_branch,
  output logic                                can_write,
  output logic [ADDR_W-1:0]                   rob_addr,
  input  logic                                update_en,
  input  logic [ADDR_W-1:0]                   update_addr,
  input  rob_entry_pkg::rob_result_u          update_result,
  input  logic                                commit_en,
  output logic                                can_commit,
  output logic [rob_entry_pkg::addr_w-1:0]     commit_pc,
  output logic [rob_entry_pkg::reg_addr_w-1:0] commit_dest,
  output logic [31:0]                         commit_value,
  output logic                                commit_is_branch,
  output logic                                commit_taken,
  output logic [31:0]                         commit_target,
  input  logic                                erase_en,
  input  logic [ADDR_W-1:0]                   erase_from_addr
);

  logic              run;
  logic              clear_en;
  logic [ADDR_W-1:0] clear_idx;
  logic [ADDR_W-1:0] head;
  logic [ADDR_W-1:0] tail;
  logic              full;
  logic              empty;
  logic              head_done;
  logic              alloc;
  logic              retire;

  // ~~~~~~~~~~~~~~~~~~~~
  // Handshake levels
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    can_write  = run && !full;
    can_commit = run && !empty && head_done;
    alloc      = write_en && can_write;
    retire     = commit_en && can_commit;
    rob_addr   = tail;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Blocks
  // ~~~~~~~~~~~~~~~~~~~~

  rob_ctrl #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) i_rob_ctrl (
    .clk       (clk),
    .rst       (rst),
    .erase_en  (erase_en),
    .run       (run),
    .clear_en  (clear_en),
    .clear_idx (clear_idx)
  );

  rob_ptr #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) i_rob_ptr (
    .clk             (clk),
    .rst             (rst),
    .alloc           (alloc),
    .retire          (retire),
    .erase_en        (erase_en),
    .erase_from_addr (erase_from_addr),
    .head            (head),
    .tail            (tail),
    .full            (full),
    .empty           (empty)
  );

  rob_store #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) i_rob_store (
    .clk             (clk),
    .rst             (rst),
    .alloc           (alloc),
    .alloc_idx       (tail),
    .pc              (write_pc),
    .dest            (write_dest),
    .is_branch       (write_is_branch),
    .update_en       (update_en),
    .update_addr     (update_addr),
    .update_result   (update_result),
    .erase_en        (erase_en),
    .erase_from_addr (erase_from_addr),
    .tail            (tail),
    .head            (head),
    .clear_en        (clear_en),
    .clear_idx       (clear_idx),
    .head_done       (head_done),
    .head_pc         (commit_pc),
    .head_dest       (commit_dest),
    .head_is_branch  (commit_is_branch),
    .head_value      (commit_value),
    .head_taken      (commit_taken),
    .head_target     (commit_target)
  );

endmodule

// File: design/rob_store.sv
`timescale 1ns/1ps

module rob_store #(
  parameter int DEPTH  = rob_cfg_pkg::rob_depth,
  parameter int ADDR_W = rob_cfg_pkg::rob_addr_w
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                alloc,
  input  logic [ADDR_W-1:0]                   alloc_idx,
  input  logic [rob_entry_pkg::addr_w-1:0]     pc,
  input  logic [rob_entry_pkg::reg_addr_w-1:0] dest,
  input  logic                                is_branch,
  input  logic                                update_en,
  input  logic [ADDR_W-1:0]                   update_addr,
  input  rob_entry_pkg::rob_result_u          update_result,
  input  logic                                erase_en,
  input  logic [ADDR_W-1:0]                   erase_from_addr,
  input  logic [ADDR_W-1:0]                   tail,
  input  logic [ADDR_W-1:0]                   head,
  input  logic                                clear_en,
  input  logic [ADDR_W-1:0]                   clear_idx,
  output logic                                head_done,
  output logic [rob_entry_pkg::addr_w-1:0]     head_pc,
  output logic [rob_entry_pkg::reg_addr_w-1:0] head_dest,
  output logic                                head_is_branch,
  output logic [31:0]                         head_value,
  output logic                                head_taken,
  output logic [31:0]                         head_target
);

  import rob_entry_pkg::*;

  logic [DEPTH-1:0]      valid_q;
  logic [DEPTH-1:0]      done_q;
  logic [DEPTH-1:0]      erase_mask;
  logic [addr_w-1:0]     pc_q     [DEPTH];
  logic [reg_addr_w-1:0] dest_q   [DEPTH];
  logic                  branch_q [DEPTH];
  rob_result_u           word_q   [DEPTH];
  rob_result_u           head_word;

  // ~~~~~~~~~~~~~~~~~~~~
  // Entry status
  // ~~~~~~~~~~~~~~~~~~~~

  // Entries whose distance past the erase tag is below the tail's distance are discarded
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      erase_mask[i] = ADDR_W'(ADDR_W'(i) - erase_from_addr)
                      < ADDR_W'(tail - erase_from_addr);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= '0;
      done_q  <= '0;
    end else begin
      for (int i = 0; i < DEPTH; i++) begin
        if ((clear_en && clear_idx == ADDR_W'(i)) || (erase_en && erase_mask[i])) begin
          valid_q[i] <= 1'b0;
          done_q[i]  <= 1'b0;
        end else if (alloc && alloc_idx == ADDR_W'(i)) begin
          valid_q[i] <= 1'b1;
          done_q[i]  <= 1'b0;
        end else if (update_en && update_addr == ADDR_W'(i) && valid_q[i]) begin
          done_q[i] <= 1'b1;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Entry payload
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (alloc) begin
      pc_q[alloc_idx]     <= pc;
      dest_q[alloc_idx]   <= dest;
      branch_q[alloc_idx] <= is_branch;
    end
    if (update_en) begin
      word_q[update_addr].data <= update_result.data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Head readout
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    head_word      = word_q[head];
    head_done      = valid_q[head] && done_q[head];
    head_pc        = pc_q[head];
    head_dest      = dest_q[head];
    head_is_branch = branch_q[head];
    head_value     = head_word.data;
    head_taken     = head_word.br.taken;
    head_target    = {head_word.br.target, 1'b0};
  end

endmodule

// File: design/rob_ptr.sv
`timescale 1ns/1ps

module rob_ptr #(
  parameter int DEPTH  = rob_cfg_pkg::rob_depth,
  parameter int ADDR_W = rob_cfg_pkg::rob_addr_w
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              alloc,
  input  logic              retire,
  input  logic              erase_en,
  input  logic [ADDR_W-1:0] erase_from_addr,
  output logic [ADDR_W-1:0] head,
  output logic [ADDR_W-1:0] tail,
  output logic              full,
  output logic              empty
);

  // One extra bit so a full buffer is told apart from an empty one
  logic [ADDR_W:0] count;

  // ~~~~~~~~~~~~~~~~~~~~
  // Head, tail and count
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else if (erase_en) begin
      // Everything from the erase tag onward is gone while the head stays put
      tail  <= erase_from_addr;
      count <= {1'b0, ADDR_W'(erase_from_addr - head)};
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      count <= count + (ADDR_W + 1)'(alloc) - (ADDR_W + 1)'(retire);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Levels
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    full  = (count == (ADDR_W + 1)'(DEPTH));
    empty = (count == '0);
  end

endmodule

// File: design/rob_ctrl.sv
`timescale 1ns/1ps

module rob_ctrl #(
  parameter int DEPTH  = rob_cfg_pkg::rob_depth,
  parameter int ADDR_W = rob_cfg_pkg::rob_addr_w
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              erase_en,
  output logic              run,
  output logic              clear_en,
  output logic [ADDR_W-1:0] clear_idx
);

  import rob_cfg_pkg::*;

  rob_state_t state;

  // ~~~~~~~~~~~~~~~~~~~~
  // State sequencing
  // ~~~~~~~~~~~~~~~~~~~~

  // The sweep visits every entry once, so the buffer opens DEPTH cycles after reset
  always_ff @(posedge clk) begin
    if (!rst) begin
      state     <= st_clear;
      clear_idx <= '0;
    end else begin
      case (state)
        st_clear: begin
          clear_idx <= clear_idx + 1'b1;
          if (clear_idx == ADDR_W'(DEPTH - 1)) begin
            state <= st_run;
          end
        end
        st_run: begin
          if (erase_en) begin
            state <= st_flush;
          end
        end
        // One bubble while the discarded entries drain out
        st_flush: begin
          state <= st_run;
        end
        default: begin
          state <= st_clear;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Outputs
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    run      = (state == st_run);
    clear_en = (state == st_clear);
  end

endmodule

// File: design/rob_entry_pkg.sv
package rob_entry_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Entry field widths
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int addr_w     = 32;
  localparam int reg_addr_w = 5;

  // ~~~~~~~~~~~~~~~~~~~~
  // Completion word
  // ~~~~~~~~~~~~~~~~~~~~

  // A branch keeps its outcome in the top bit and the target word address below it
  typedef struct packed {
    logic        taken;
    logic [30:0] target;
  } rob_branch_t;

  // The same 32 bits are a result for a plain instruction and an outcome for a branch
  typedef union packed {
    logic [31:0] data;
    rob_branch_t br;
  } rob_result_u;

endpackage

// File: design/rob_cfg_pkg.sv
package rob_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Buffer sizing
  // ~~~~~~~~~~~~~~~~~~~~

  // The number of entries stays a power of two so tags wrap naturally
  localparam int rob_depth = 8;

  // Width of a tag
  localparam int rob_addr_w = $clog2(rob_depth);

  // ~~~~~~~~~~~~~~~~~~~~
  // Controller states
  // ~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    st_clear = 2'd0,
    st_run   = 2'd1,
    st_flush = 2'd2
  } rob_state_t;

endpackage
